/* common/irq_pkg.sv */
package irq_pkg;

    // Byte address in program memory.
    typedef logic [31:0] addr_t;

    // One keyboard scancode as delivered by the receiver.
    typedef logic [7:0] scancode_t;

    // Interrupt number, also the index into the vector table.
    typedef logic [2:0] irq_type_t;

    // Number of vector table entries.
    localparam int NUM_INTERRUPTS = 8;

    // Interrupt numbers.
    localparam irq_type_t IRQ_TYPE_KEY = 3'd0;

    // Instruction layout.
    localparam int OPERATION_SIZE_BYTES = 1;
    localparam int OPERAND_SIZE_BYTES = 4;

    // One operation byte plus two operands.
    localparam addr_t INSTR_SIZE_BYTES =
        addr_t'(OPERATION_SIZE_BYTES + 2 * OPERAND_SIZE_BYTES);

    // One queued interrupt, kind and value travel together.
    typedef struct packed {
        irq_type_t kind;
        addr_t     value;
    } irq_rec_t;

endpackage

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DEPTH = 5,
    parameter type item_t = logic [7:0]
) (
    input  logic  CLOCK_50,
    input  logic  rst_i,
    input  logic  wr_i,
    input  item_t wr_data_i,
    input  logic  rd_i,
    output item_t rd_data_o,
    output logic  empty_o,
    output logic  full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // Accesses beyond the limits are simply ignored.
    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    always_ff @(posedge CLOCK_50)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_data_i;
        end
        // Read data holds until the next read.
        if (do_rd)
        begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count alone.
            if (do_wr && !do_rd)
            begin
                count <= count + 1'b1;
            end
            else if (do_rd && !do_wr)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* irq/irq_poster.sv */
`timescale 1ns/1ps

module irq_poster
    import irq_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      rst_i,
    input  logic      scan_empty_i,
    input  scancode_t scan_data_i,
    input  logic      queue_full_i,
    output logic      scan_rd_o,
    output logic      queue_wr_o,
    output irq_rec_t  queue_data_o
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t state;

    // Only start a move when the queue can take the record.
    // The poster is the only writer, so room stays there one cycle later.
    assign scan_rd_o = (state == ST_IDLE) && !scan_empty_i && !queue_full_i;

    // The scancode read data is valid in the write state.
    assign queue_wr_o = (state == ST_WRITE);

    always_comb
    begin
        queue_data_o.kind  = IRQ_TYPE_KEY;
        queue_data_o.value = addr_t'(scan_data_i);
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (scan_rd_o)
                    begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE:
                begin
                    state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* irq/irq_dispatch.sv */
`timescale 1ns/1ps

module irq_dispatch
    import irq_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      rst_i,
    input  logic      step_i,
    input  logic      isr_done_i,
    input  addr_t     ip_i,
    input  addr_t     prog_end_i,
    input  addr_t     code_base_i,
    input  logic      vec_wr_i,
    input  irq_type_t vec_idx_i,
    input  addr_t     vec_addr_i,
    input  logic      queue_empty_i,
    input  irq_rec_t  queue_data_i,
    output logic      queue_rd_o,
    output logic      irq_take_o,
    output logic      in_isr_o,
    output addr_t     irq_target_o,
    output addr_t     irq_value_o,
    output addr_t     irq_return_o
);

    // Vector table, entry n is the ISR offset from the code base.
    addr_t vec_table [NUM_INTERRUPTS];

    // High in the cycle after a pop, while the queue read data arrives.
    logic  pop_q;
    addr_t next_ip;
    addr_t ret_q;

    assign next_ip = ip_i + INSTR_SIZE_BYTES;

    // Steps during a pending take or while in service are ignored.
    assign queue_rd_o = step_i && !in_isr_o && !pop_q && !queue_empty_i;

    // Return address is captured at the accepted step.
    always_ff @(posedge CLOCK_50)
    begin
        if (queue_rd_o)
        begin
            ret_q <= (next_ip >= prog_end_i) ? ip_i : next_ip;
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < NUM_INTERRUPTS; i++)
            begin
                vec_table[i] <= '0;
            end
        end
        else if (vec_wr_i)
        begin
            vec_table[vec_idx_i] <= vec_addr_i;
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            pop_q        <= 1'b0;
            irq_take_o   <= 1'b0;
            in_isr_o     <= 1'b0;
            irq_target_o <= '0;
            irq_value_o  <= '0;
            irq_return_o <= '0;
        end
        else
        begin
            pop_q      <= queue_rd_o;
            irq_take_o <= pop_q;
            if (pop_q)
            begin
                // Record is on the queue output now, jump into its ISR.
                in_isr_o     <= 1'b1;
                irq_target_o <= code_base_i + vec_table[queue_data_i.kind];
                irq_value_o  <= queue_data_i.value;
                irq_return_o <= ret_q;
            end
            else if (isr_done_i)
            begin
                in_isr_o <= 1'b0;
            end
        end
    end

endmodule

/* design/irq_top.sv */
`timescale 1ns/1ps

module irq_top
    import irq_pkg::*;
#(
    parameter int SCAN_DEPTH = 5,
    parameter int QUEUE_DEPTH = 10
) (
    input  logic      CLOCK_50,
    input  logic      rst_i,
    input  logic      scan_valid_i,
    input  scancode_t scan_code_i,
    input  logic      step_i,
    input  logic      isr_done_i,
    input  addr_t     ip_i,
    input  addr_t     prog_end_i,
    input  addr_t     code_base_i,
    input  logic      vec_wr_i,
    input  irq_type_t vec_idx_i,
    input  addr_t     vec_addr_i,
    output logic      scan_drop_o,
    output logic      irq_take_o,
    output logic      in_isr_o,
    output addr_t     irq_target_o,
    output addr_t     irq_value_o,
    output addr_t     irq_return_o
);

    logic      scan_rd;
    logic      scan_empty;
    logic      scan_full;
    scancode_t scan_data;
    logic      queue_wr;
    logic      queue_rd;
    logic      queue_empty;
    logic      queue_full;
    irq_rec_t  queue_wr_data;
    irq_rec_t  queue_rd_data;

    // A strobe into a full scancode FIFO loses the code.
    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            scan_drop_o <= 1'b0;
        end
        else
        begin
            scan_drop_o <= scan_valid_i && scan_full;
        end
    end

    sync_fifo #(
        .DEPTH  (SCAN_DEPTH),
        .item_t (scancode_t)
    ) i_scan_fifo (
        .CLOCK_50  (CLOCK_50),
        .rst_i     (rst_i),
        .wr_i      (scan_valid_i),
        .wr_data_i (scan_code_i),
        .rd_i      (scan_rd),
        .rd_data_o (scan_data),
        .empty_o   (scan_empty),
        .full_o    (scan_full)
    );

    irq_poster i_irq_poster (
        .CLOCK_50     (CLOCK_50),
        .rst_i        (rst_i),
        .scan_empty_i (scan_empty),
        .scan_data_i  (scan_data),
        .queue_full_i (queue_full),
        .scan_rd_o    (scan_rd),
        .queue_wr_o   (queue_wr),
        .queue_data_o (queue_wr_data)
    );

    // Interrupt queue, one record per pending interrupt.
    sync_fifo #(
        .DEPTH  (QUEUE_DEPTH),
        .item_t (irq_rec_t)
    ) i_irq_queue (
        .CLOCK_50  (CLOCK_50),
        .rst_i     (rst_i),
        .wr_i      (queue_wr),
        .wr_data_i (queue_wr_data),
        .rd_i      (queue_rd),
        .rd_data_o (queue_rd_data),
        .empty_o   (queue_empty),
        .full_o    (queue_full)
    );

    irq_dispatch i_irq_dispatch (
        .CLOCK_50      (CLOCK_50),
        .rst_i         (rst_i),
        .step_i        (step_i),
        .isr_done_i    (isr_done_i),
        .ip_i          (ip_i),
        .prog_end_i    (prog_end_i),
        .code_base_i   (code_base_i),
        .vec_wr_i      (vec_wr_i),
        .vec_idx_i     (vec_idx_i),
        .vec_addr_i    (vec_addr_i),
        .queue_empty_i (queue_empty),
        .queue_data_i  (queue_rd_data),
        .queue_rd_o    (queue_rd),
        .irq_take_o    (irq_take_o),
        .in_isr_o      (in_isr_o),
        .irq_target_o  (irq_target_o),
        .irq_value_o   (irq_value_o),
        .irq_return_o  (irq_return_o)
    );

endmodule

/* dv/irq_top_sva.sv */
`timescale 1ns/1ps

module irq_top_sva (
    input logic CLOCK_50,
    input logic rst_i,
    input logic scan_valid_i,
    input logic scan_drop_o,
    input logic irq_take_o,
    input logic in_isr_o
);

    // No nested service routine.
    take_outside_isr: assert property (
        @(posedge CLOCK_50) disable iff (rst_i)
        irq_take_o |-> !$past(in_isr_o)
    ) else $error("irq_take_o while already in service");

    take_one_cycle: assert property (
        @(posedge CLOCK_50) disable iff (rst_i)
        irq_take_o |=> !irq_take_o
    ) else $error("irq_take_o longer than one cycle");

    // A drop is the registered echo of a strobe.
    drop_after_strobe: assert property (
        @(posedge CLOCK_50) disable iff (rst_i)
        scan_drop_o |-> $past(scan_valid_i)
    ) else $error("scan_drop_o without a scan_valid_i strobe");

endmodule

bind irq_top irq_top_sva i_irq_top_sva (
    .CLOCK_50     (CLOCK_50),
    .rst_i        (rst_i),
    .scan_valid_i (scan_valid_i),
    .scan_drop_o  (scan_drop_o),
    .irq_take_o   (irq_take_o),
    .in_isr_o     (in_isr_o)
);

/* dv/irq_tb.sv */
`timescale 1ns/1ps

module irq_tb
    import irq_pkg::*;
;

    logic      CLOCK_50;
    logic      rst_i;
    logic      scan_valid_i;
    scancode_t scan_code_i;
    logic      step_i;
    logic      isr_done_i;
    addr_t     ip_i;
    addr_t     prog_end_i;
    addr_t     code_base_i;
    logic      vec_wr_i;
    irq_type_t vec_idx_i;
    addr_t     vec_addr_i;
    logic      scan_drop_o;
    logic      irq_take_o;
    logic      in_isr_o;
    addr_t     irq_target_o;
    addr_t     irq_value_o;
    addr_t     irq_return_o;

    integer    seed;
    int        err_cnt;
    int        timeout_cnt;
    bit        timed_out;

    // Reference model state.
    addr_t     vec_model [NUM_INTERRUPTS];
    scancode_t codes [$];
    int        strobe_cnt;
    int        drop_cnt;
    int        take_cnt;
    int        wrap_cnt;

    // One and two cycle history as seen at the falling edge.
    logic      step_d1;
    logic      step_d2;
    addr_t     ip_d1;
    addr_t     ip_d2;
    addr_t     pe_d1;
    addr_t     pe_d2;
    logic      isr_d1;
    logic      done_d1;
    scancode_t exp_code;
    addr_t     exp_ret;

    irq_top i_irq_top (.*);

    initial
    begin
        CLOCK_50 = 1'b0;
        forever
        begin
            #10 CLOCK_50 = ~CLOCK_50;
        end
    end

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_code(input scancode_t got, input scancode_t exp, input string what);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One clock of random stimulus.
    task automatic drive_random(input bit scan_en, input int scan_mask, input bit step_en);
        addr_t ip;
        addr_t span;
        @(posedge CLOCK_50);
        ip = addr_t'($random(seed)) & 32'h00ff_fffc;
        span = addr_t'($random(seed)) & 32'h0000_000f;
        scan_valid_i <= scan_en && (($random(seed) & scan_mask) == 0);
        scan_code_i  <= scancode_t'($random(seed));
        step_i       <= step_en && (($random(seed) & 1) != 0);
        isr_done_i   <= step_en && (($random(seed) & 3) == 0);
        ip_i         <= ip;
        // Span 1 to 16 bytes, so the end of program is often hit.
        prog_end_i   <= ip + span + 1;
    endtask

    // Keeps stepping until every accepted scancode has been taken.
    task automatic wait_drained(input int limit, input string what);
        int cycles;
        cycles = 0;
        while ((take_cnt != strobe_cnt - drop_cnt) && (cycles < limit))
        begin
            drive_random(1'b0, 0, 1'b1);
            cycles++;
        end
        if (take_cnt != strobe_cnt - drop_cnt)
        begin
            timed_out = 1'b1;
            timeout_cnt++;
            $display("Timeout: %s never came, %0d of %0d takes seen", what, take_cnt,
                     strobe_cnt - drop_cnt);
        end
        @(posedge CLOCK_50);
        step_i     <= 1'b0;
        isr_done_i <= 1'b0;
    endtask

    always @(negedge CLOCK_50)
    begin
        if (rst_i)
        begin
            step_d1 = 1'b0;
            step_d2 = 1'b0;
            isr_d1  = 1'b0;
            done_d1 = 1'b0;
        end
        else
        begin
            // A drop always refers to the strobe one cycle back.
            if (scan_drop_o)
            begin
                drop_cnt++;
                if (codes.size() == 0)
                begin
                    err_cnt++;
                    $display("Error at %0t: scan_drop_o without a pending strobe", $time);
                end
                else
                begin
                    void'(codes.pop_back());
                end
            end
            if (scan_valid_i)
            begin
                codes.push_back(scan_code_i);
                strobe_cnt++;
            end
            if (irq_take_o)
            begin
                take_cnt++;
                check_flag(step_d2, 1'b1, "step_i two cycles before take");
                check_flag(isr_d1, 1'b0, "in_isr_o before take");
                check_flag(in_isr_o, 1'b1, "in_isr_o at take");
                if (codes.size() == 0)
                begin
                    err_cnt++;
                    $display("Error at %0t: take with no pending scancode", $time);
                end
                else
                begin
                    exp_code = codes.pop_front();
                    check_code(scancode_t'(irq_value_o), exp_code, "irq_value_o scancode");
                    check_addr(irq_value_o, addr_t'(exp_code), "irq_value_o");
                end
                exp_ret = ip_d2 + INSTR_SIZE_BYTES;
                if (exp_ret >= pe_d2)
                begin
                    exp_ret = ip_d2;
                    wrap_cnt++;
                end
                check_addr(irq_return_o, exp_ret, "irq_return_o");
                check_addr(irq_target_o, code_base_i + vec_model[IRQ_TYPE_KEY], "irq_target_o");
            end
            else if (done_d1)
            begin
                check_flag(in_isr_o, 1'b0, "in_isr_o after isr_done_i");
            end
            step_d2 = step_d1;
            step_d1 = step_i;
            ip_d2   = ip_d1;
            ip_d1   = ip_i;
            pe_d2   = pe_d1;
            pe_d1   = prog_end_i;
            isr_d1  = in_isr_o;
            done_d1 = isr_done_i;
        end
    end

    initial
    begin
        int    burst_strobes;
        int    burst_drops;
        int    burst_takes;
        addr_t vec;
        seed         = 32'h907b_ce0f;
        err_cnt      = 0;
        timeout_cnt  = 0;
        timed_out    = 1'b0;
        strobe_cnt   = 0;
        drop_cnt     = 0;
        take_cnt     = 0;
        wrap_cnt     = 0;
        rst_i        = 1'b1;
        scan_valid_i = 1'b0;
        scan_code_i  = '0;
        step_i       = 1'b0;
        isr_done_i   = 1'b0;
        ip_i         = '0;
        prog_end_i   = '0;
        code_base_i  = '0;
        vec_wr_i     = 1'b0;
        vec_idx_i    = '0;
        vec_addr_i   = '0;
        for (int i = 0; i < NUM_INTERRUPTS; i++)
        begin
            vec_model[i] = '0;
        end
        repeat (10) @(posedge CLOCK_50);
        rst_i <= 1'b0;

        // Outputs are quiet after reset.
        @(negedge CLOCK_50);
        check_flag(irq_take_o, 1'b0, "irq_take_o after reset");
        check_flag(in_isr_o, 1'b0, "in_isr_o after reset");
        check_flag(scan_drop_o, 1'b0, "scan_drop_o after reset");
        check_addr(irq_target_o, '0, "irq_target_o after reset");
        check_addr(irq_value_o, '0, "irq_value_o after reset");
        check_addr(irq_return_o, '0, "irq_return_o after reset");

        // Scancodes without steps must not be taken.
        repeat (30) drive_random(1'b1, 3, 1'b0);
        check_flag(take_cnt != 0, 1'b0, "take seen without step_i");

        for (int i = 0; i < NUM_INTERRUPTS; i++)
        begin
            @(posedge CLOCK_50);
            vec = addr_t'($random(seed)) & 32'h00ff_fff0;
            scan_valid_i <= 1'b0;
            vec_wr_i     <= 1'b1;
            vec_idx_i    <= irq_type_t'(i);
            vec_addr_i   <= vec;
            vec_model[i] = vec;
        end
        @(posedge CLOCK_50);
        vec_wr_i    <= 1'b0;
        code_base_i <= addr_t'($random(seed)) & 32'h7f00_0000;

        repeat (200) drive_random(1'b1, 3, 1'b1);
        wait_drained(3000, "drain of the random phase");
        if (!timed_out && (wrap_cnt == 0))
        begin
            err_cnt++;
            $display("Error at %0t: return address at program end was never exercised", $time);
        end

        // Back-to-back strobes with no steps overflow the scancode FIFO.
        if (!timed_out)
        begin
            burst_strobes = strobe_cnt;
            burst_drops   = drop_cnt;
            burst_takes   = take_cnt;
            repeat (20) drive_random(1'b1, 0, 1'b0);
            // The drop of the last strobe is seen one cycle after it.
            repeat (2) drive_random(1'b0, 0, 1'b0);
            burst_strobes = strobe_cnt - burst_strobes;
            burst_drops   = drop_cnt - burst_drops;
            check_flag(burst_drops > 0, 1'b1, "drops during the burst");
            wait_drained(3000, "drain of the burst");
            // Further steps must not bring any extra take.
            repeat (50) drive_random(1'b0, 0, 1'b1);
            check_flag((take_cnt - burst_takes) == (burst_strobes - burst_drops), 1'b1,
                       "takes equal strobes minus drops");
        end

        $display("Checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0))
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb.f */
common/irq_pkg.sv
design/sync_fifo.sv
irq/irq_poster.sv
irq/irq_dispatch.sv
design/irq_top.sv
dv/irq_top_sva.sv
dv/irq_tb.sv
